// File: verilog/dma_pkg.sv
package dma_pkg;

	////////////////////////////////////////
	// sizing
	////////////////////////////////////////
	localparam int unsigned AddrWidth      = 32;
	localparam int unsigned DataWidth      = 32;
	localparam int unsigned BeWidth        = 4;
	localparam int unsigned MaxOutstanding = 2; // per engine, also owner queue depth
	localparam int unsigned OustWidth      = $clog2(MaxOutstanding + 1);
	localparam int unsigned QPtrWidth      = $clog2(MaxOutstanding);

	localparam logic [DataWidth-1:0] IdMagic  = 32'h69434017; // id word at offset 0
	localparam logic [DataWidth-1:0] FillWord = 32'hdeadbeef; // unmapped offsets
	localparam logic [DataWidth-1:0] LenReset = 32'd4;        // one word

	// word offsets of the register map
	typedef enum logic [2:0] {
		RegId     = 3'd0,
		RegRdCmd  = 3'd1, // write starts read, read gives capture 0
		RegCap1   = 3'd2,
		RegCap2   = 3'd3,
		RegLen    = 3'd4,
		RegWrCmd  = 3'd5,
		RegWrData = 3'd6  // write pushes data, read gives status
	} reg_off_e;

	// manager port owner
	typedef enum logic {
		OwnRd = 1'b0,
		OwnWr = 1'b1
	} owner_e;

	////////////////////////////////////////
	// bus and stream types
	////////////////////////////////////////
	typedef struct packed {
		logic                 req;
		logic [AddrWidth-1:0] addr;
		logic                 we;
		logic [BeWidth-1:0]   be;
		logic [DataWidth-1:0] wdata;
	} obi_req_t;

	typedef struct packed {
		logic                 gnt;
		logic                 rvalid;
		logic [DataWidth-1:0] rdata;
	} obi_rsp_t;

	typedef struct packed {
		logic                 valid; // single cycle strobe
		logic [AddrWidth-1:0] addr;  // byte address
		logic [DataWidth-1:0] len;   // bytes
	} dma_cmd_t;

	typedef struct packed {
		logic                 valid;
		logic [DataWidth-1:0] data;
		logic [BeWidth-1:0]   be;
		logic                 last;
	} stream_t;

	// enables from a byte offset up to the word end
	function automatic logic [BeWidth-1:0] head_be(input logic [1:0] off);
		return 4'b1111 << off;
	endfunction

	// enables of a word holding n bytes, 0 means full word
	function automatic logic [BeWidth-1:0] tail_be(input logic [1:0] n);
		return (n == 2'd0) ? 4'b1111 : ~(4'b1111 << n);
	endfunction

endpackage

// File: verilog/dma_regs.sv
module dma_regs import dma_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  obi_req_t sbr_req_i,
	output obi_rsp_t sbr_rsp_o,
	output dma_cmd_t rd_cmd_o,
	output dma_cmd_t wr_cmd_o,
	input  stream_t  rd_word_i,
	output stream_t  wr_word_o,
	input  logic     wr_data_ready_i,
	input  logic     rd_idle_i,
	input  logic     wr_idle_i
);

	logic     acc;    // accepted request
	logic     wr_acc; // accepted write inside the map window
	logic     hit;
	reg_off_e off;

	assign acc    = sbr_req_i.req; // gnt is tied high
	assign hit    = sbr_req_i.addr[11:5] == '0;
	assign off    = reg_off_e'(sbr_req_i.addr[4:2]);
	assign wr_acc = acc & sbr_req_i.we & hit;

	////////////////////////////////////////
	// response pipe
	////////////////////////////////////////
	logic     rvalid_q;
	logic     rd_hit_q;
	reg_off_e rd_off_q;

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= acc; // reads and writes both answered
		end
	end

	always_ff @(posedge clk_i) begin
		if (acc) begin
			rd_off_q <= off;
			rd_hit_q <= hit;
		end
	end

	// shared transfer length
	logic [DataWidth-1:0] len_q;
	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			len_q <= LenReset;
		end else if (wr_acc && off == RegLen) begin
			len_q <= sbr_req_i.wdata;
		end
	end

	////////////////////////////////////////
	// engine strobes
	////////////////////////////////////////
	assign rd_cmd_o.valid = wr_acc && (off == RegRdCmd);
	assign rd_cmd_o.addr  = sbr_req_i.wdata;
	assign rd_cmd_o.len   = len_q;

	assign wr_cmd_o.valid = wr_acc && (off == RegWrCmd);
	assign wr_cmd_o.addr  = sbr_req_i.wdata;
	assign wr_cmd_o.len   = len_q;

	assign wr_word_o.valid = wr_acc && (off == RegWrData); // lost if engine not ready
	assign wr_word_o.data  = sbr_req_i.wdata;
	assign wr_word_o.be    = '1;
	assign wr_word_o.last  = 1'b0; // engine counts words itself

	// newest three read stream words, word 0 is the newest
	logic [2:0][DataWidth-1:0] cap_q;
	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			cap_q <= '0;
		end else if (rd_word_i.valid) begin
			cap_q <= {cap_q[1:0], rd_word_i.data};
		end
	end

	logic [DataWidth-1:0] status;
	logic [DataWidth-1:0] rdata;

	always_comb begin
		status      = '0;
		status[2:0] = {rd_idle_i, wr_data_ready_i, wr_idle_i};
		rdata       = FillWord;
		if (rd_hit_q) begin
			case (rd_off_q)
				RegId:     rdata = IdMagic;
				RegRdCmd:  rdata = cap_q[0];
				RegCap1:   rdata = cap_q[1];
				RegCap2:   rdata = cap_q[2];
				RegLen:    rdata = len_q;
				RegWrData: rdata = status;
				default:   rdata = FillWord; // write cmd and offset 7
			endcase
		end
	end

	assign sbr_rsp_o.gnt    = 1'b1;
	assign sbr_rsp_o.rvalid = rvalid_q;
	assign sbr_rsp_o.rdata  = rdata;

	// one response per request, exactly a cycle later
	a_rvalid_after_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
		sbr_rsp_o.rvalid |-> $past(sbr_req_i.req));

endmodule

// File: verilog/read_dma.sv
module read_dma import dma_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  dma_cmd_t cmd_i,
	output obi_req_t mgr_req_o,
	input  obi_rsp_t mgr_rsp_i,
	output stream_t  word_o,
	output logic     idle_o
);

	logic                 start;
	logic                 fire; // request granted
	logic [DataWidth-1:0] n_rd;  // aligned words to fetch
	logic [DataWidth-1:0] n_out; // stream words to emit

	assign start = cmd_i.valid & idle_o; // busy engine drops the strobe
	assign fire  = mgr_req_o.req & mgr_rsp_i.gnt;
	assign n_rd  = (cmd_i.len + DataWidth'(cmd_i.addr[1:0]) + DataWidth'(3)) >> 2;
	assign n_out = (cmd_i.len + DataWidth'(3)) >> 2;

	////////////////////////////////////////
	// address side
	////////////////////////////////////////
	logic [DataWidth-1:0] left_q;  // requests still to issue
	logic                 first_q;
	logic [AddrWidth-3:0] waddr_q;
	logic [1:0]           off_q;
	logic                 dbl_q;   // extra flush word at the end
	logic [BeWidth-1:0]   last_be_q;

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			left_q  <= '0;
			first_q <= 1'b0;
		end else if (start) begin
			left_q  <= n_rd;
			first_q <= 1'b1;
		end else if (fire) begin
			left_q  <= left_q - 1'b1;
			first_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (start) begin
			waddr_q   <= cmd_i.addr[AddrWidth-1:2];
			off_q     <= cmd_i.addr[1:0];
			dbl_q     <= (cmd_i.addr[1:0] != 2'd0) && (n_rd == n_out);
			last_be_q <= tail_be(cmd_i.len[1:0]);
		end else if (fire) begin
			waddr_q <= waddr_q + 1'b1;
		end
	end

	// outstanding count and {first, last} flags per request
	logic [OustWidth-1:0] oust_q;
	logic [QPtrWidth-1:0] fq_wr_q, fq_rd_q;
	logic [1:0]           fq_q [MaxOutstanding];

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			oust_q  <= '0;
			fq_wr_q <= '0;
			fq_rd_q <= '0;
		end else begin
			oust_q <= oust_q + OustWidth'(fire) - OustWidth'(mgr_rsp_i.rvalid);
			if (fire) fq_wr_q <= fq_wr_q + 1'b1;
			if (mgr_rsp_i.rvalid) fq_rd_q <= fq_rd_q + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (fire) fq_q[fq_wr_q] <= {first_q, left_q == DataWidth'(1)};
	end

	assign mgr_req_o.req   = (left_q != '0) && (oust_q < OustWidth'(MaxOutstanding));
	assign mgr_req_o.addr  = {waddr_q, 2'b00}; // aligned words only
	assign mgr_req_o.we    = 1'b0;
	assign mgr_req_o.be    = '1;
	assign mgr_req_o.wdata = '0;

	////////////////////////////////////////
	// realign
	////////////////////////////////////////
	logic [6:0][7:0]      in_q; // newest word on top, 3 older bytes below
	logic                 in_first_q, in_last_q;
	logic                 in_vld_q, flush_q, out_vld_q, out_last_q;
	logic                 keep;
	logic [DataWidth-1:0] out_q;

	assign keep = in_vld_q && (off_q == 2'd0 || !in_first_q); // leading partial word dropped

	always_ff @(posedge clk_i) begin
		if (mgr_rsp_i.rvalid) begin
			in_q[6:3]                <= mgr_rsp_i.rdata;
			in_q[2:0]                <= in_q[6:4];
			{in_first_q, in_last_q} <= fq_q[fq_rd_q];
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			in_vld_q  <= 1'b0;
			flush_q   <= 1'b0;
			out_vld_q <= 1'b0;
		end else begin
			in_vld_q  <= mgr_rsp_i.rvalid;
			flush_q   <= in_vld_q && in_last_q && dbl_q;
			out_vld_q <= keep || flush_q;
		end
	end

	always_ff @(posedge clk_i) begin
		if (flush_q) begin // tail bytes of the last fetched word
			out_last_q <= 1'b1;
			case (off_q)
				2'd1:    out_q <= {8'h00, in_q[6:4]};
				2'd2:    out_q <= {16'h0000, in_q[6:5]};
				default: out_q <= {24'h000000, in_q[6]};
			endcase
		end else if (keep) begin
			out_last_q <= in_last_q && !dbl_q;
			case (off_q)
				2'd0:    out_q <= in_q[6:3];
				2'd1:    out_q <= in_q[3:0];
				2'd2:    out_q <= in_q[4:1];
				default: out_q <= in_q[5:2];
			endcase
		end
	end

	logic [BeWidth-1:0] out_be;
	assign out_be = out_last_q ? last_be_q : '1;

	always_comb begin
		word_o.valid = out_vld_q;
		word_o.be    = out_be;
		word_o.last  = out_last_q;
		for (int b = 0; b < BeWidth; b++) begin
			word_o.data[8*b +: 8] = out_be[b] ? out_q[8*b +: 8] : 8'h00; // zero past length
		end
	end

	assign idle_o = (left_q == '0) && (oust_q == '0) && !in_vld_q && !flush_q && !out_vld_q;

	a_oust_limit : assert property (@(posedge clk_i) disable iff (!rst_ni)
		oust_q <= OustWidth'(MaxOutstanding));

endmodule

// File: verilog/write_dma.sv
module write_dma import dma_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  dma_cmd_t cmd_i,
	input  stream_t  word_i,
	output obi_req_t mgr_req_o,
	input  obi_rsp_t mgr_rsp_i,
	output logic     data_ready_o,
	output logic     idle_o
);

	logic                 start, fire;
	logic                 push, flush_go, take, move, room;
	logic [DataWidth-1:0] n_wr; // aligned words to write
	logic [DataWidth-1:0] n_in; // stream words to take

	assign start = cmd_i.valid & idle_o;
	assign fire  = mgr_req_o.req & mgr_rsp_i.gnt;
	assign n_wr  = (cmd_i.len + DataWidth'(cmd_i.addr[1:0]) + DataWidth'(3)) >> 2;
	assign n_in  = (cmd_i.len + DataWidth'(3)) >> 2;

	////////////////////////////////////////
	// control
	////////////////////////////////////////
	logic [DataWidth-1:0] wr_left_q, in_left_q;
	logic                 flush_pend_q; // range spills into one more word
	logic                 take_first_q;
	logic                 in_vld_q, out_vld_q;
	logic [OustWidth-1:0] oust_q;

	assign room         = !in_vld_q || !out_vld_q; // registered only, stays true until push
	assign data_ready_o = (in_left_q != '0) && room;
	assign push         = word_i.valid && data_ready_o;
	assign flush_go     = flush_pend_q && (in_left_q == '0) && room; // internal zero word
	assign take         = push || flush_go;
	assign move         = in_vld_q && (!out_vld_q || fire);

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			wr_left_q    <= '0;
			in_left_q    <= '0;
			flush_pend_q <= 1'b0;
			take_first_q <= 1'b0;
			in_vld_q     <= 1'b0;
			out_vld_q    <= 1'b0;
			oust_q       <= '0;
		end else begin
			if (start) begin
				wr_left_q    <= n_wr;
				in_left_q    <= n_in;
				flush_pend_q <= n_wr != n_in;
				take_first_q <= 1'b1;
			end else begin
				if (fire) wr_left_q <= wr_left_q - 1'b1;
				if (push) in_left_q <= in_left_q - 1'b1;
				if (flush_go) flush_pend_q <= 1'b0;
				if (take) take_first_q <= 1'b0;
			end
			in_vld_q  <= take || (in_vld_q && !move);
			out_vld_q <= move || (out_vld_q && !fire);
			oust_q    <= oust_q + OustWidth'(fire) - OustWidth'(mgr_rsp_i.rvalid);
		end
	end

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////
	logic [6:0][7:0]      in_q; // new word on top, older 3 bytes below
	logic                 in_first_q, in_last_q;
	logic [AddrWidth-3:0] waddr_q;
	logic [1:0]           off_q;
	logic [BeWidth-1:0]   first_be_q, last_be_q, out_be_q;
	logic [DataWidth-1:0] out_q;

	always_ff @(posedge clk_i) begin
		if (start) begin
			waddr_q    <= cmd_i.addr[AddrWidth-1:2];
			off_q      <= cmd_i.addr[1:0];
			first_be_q <= head_be(cmd_i.addr[1:0]);
			last_be_q  <= tail_be(cmd_i.addr[1:0] + cmd_i.len[1:0]);
		end else if (fire) begin
			waddr_q <= waddr_q + 1'b1;
		end
		if (take) begin
			in_q[6:3]  <= flush_go ? '0 : word_i.data;
			in_q[2:0]  <= in_q[6:4];
			in_first_q <= take_first_q;
			in_last_q  <= flush_go || (in_left_q == DataWidth'(1) && !flush_pend_q);
		end
		if (move) begin
			out_be_q <= (in_first_q ? first_be_q : '1) & (in_last_q ? last_be_q : '1);
			case (off_q)
				2'd0:    out_q <= in_q[6:3];
				2'd1:    out_q <= in_q[5:2];
				2'd2:    out_q <= in_q[4:1];
				default: out_q <= in_q[3:0];
			endcase
		end
	end

	// request held in out_q until granted
	assign mgr_req_o.req   = out_vld_q && (oust_q < OustWidth'(MaxOutstanding));
	assign mgr_req_o.addr  = {waddr_q, 2'b00};
	assign mgr_req_o.we    = 1'b1;
	assign mgr_req_o.be    = out_be_q;
	assign mgr_req_o.wdata = out_q;

	assign idle_o = (wr_left_q == '0) && (oust_q == '0); // after last response

	a_be_nonzero : assert property (@(posedge clk_i) disable iff (!rst_ni)
		fire |-> (mgr_req_o.be != '0));

endmodule

// File: verilog/mgr_arbiter.sv
module mgr_arbiter import dma_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  obi_req_t wr_req_i,
	input  obi_req_t rd_req_i,
	output obi_rsp_t wr_rsp_o,
	output obi_rsp_t rd_rsp_o,
	output obi_req_t mgr_req_o,
	input  obi_rsp_t mgr_rsp_i
);

	owner_e               sel, head;
	owner_e               own_q [MaxOutstanding]; // owner per granted request
	logic [QPtrWidth-1:0] wr_ptr_q, rd_ptr_q;
	logic [OustWidth-1:0] cnt_q;
	logic                 full, fire;

	assign sel  = wr_req_i.req ? OwnWr : OwnRd; // write wins
	assign full = cnt_q == OustWidth'(MaxOutstanding);
	assign fire = mgr_req_o.req & mgr_rsp_i.gnt;
	assign head = own_q[rd_ptr_q];

	always_comb begin
		mgr_req_o     = (sel == OwnWr) ? wr_req_i : rd_req_i;
		mgr_req_o.req = mgr_req_o.req & !full; // hold off while queue full
		wr_rsp_o        = mgr_rsp_i;
		rd_rsp_o        = mgr_rsp_i;
		wr_rsp_o.gnt    = mgr_rsp_i.gnt && !full && (sel == OwnWr);
		rd_rsp_o.gnt    = mgr_rsp_i.gnt && !full && (sel == OwnRd);
		wr_rsp_o.rvalid = mgr_rsp_i.rvalid && (head == OwnWr); // in order
		rd_rsp_o.rvalid = mgr_rsp_i.rvalid && (head == OwnRd);
	end

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			cnt_q    <= '0;
		end else begin
			if (fire) wr_ptr_q <= wr_ptr_q + 1'b1;
			if (mgr_rsp_i.rvalid) rd_ptr_q <= rd_ptr_q + 1'b1;
			cnt_q <= cnt_q + OustWidth'(fire) - OustWidth'(mgr_rsp_i.rvalid);
		end
	end

	always_ff @(posedge clk_i) begin
		if (fire) own_q[wr_ptr_q] <= sel;
	end

	a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
		cnt_q <= OustWidth'(MaxOutstanding));
	// a response needs a granted request behind it
	a_no_stray_rsp : assert property (@(posedge clk_i) disable iff (!rst_ni)
		mgr_rsp_i.rvalid |-> (cnt_q != '0));

endmodule

// File: verilog/dma_top.sv
module dma_top import dma_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  obi_req_t sbr_req_i,
	output obi_rsp_t sbr_rsp_o,
	output obi_req_t mgr_req_o,
	input  obi_rsp_t mgr_rsp_i
);

	dma_cmd_t rd_cmd, wr_cmd;
	stream_t  rd_word, wr_word;
	logic     wr_ready, rd_idle, wr_idle;
	obi_req_t rd_req, wr_req; // engine side of the arbiter
	obi_rsp_t rd_rsp, wr_rsp;

	dma_regs u_regs (
		.clk_i           ( clk_i     ),
		.rst_ni          ( rst_ni    ),
		.sbr_req_i       ( sbr_req_i ),
		.sbr_rsp_o       ( sbr_rsp_o ),
		.rd_cmd_o        ( rd_cmd    ),
		.wr_cmd_o        ( wr_cmd    ),
		.rd_word_i       ( rd_word   ),
		.wr_word_o       ( wr_word   ),
		.wr_data_ready_i ( wr_ready  ),
		.rd_idle_i       ( rd_idle   ),
		.wr_idle_i       ( wr_idle   )
	);

	read_dma u_read (
		.clk_i     ( clk_i   ),
		.rst_ni    ( rst_ni  ),
		.cmd_i     ( rd_cmd  ),
		.mgr_req_o ( rd_req  ),
		.mgr_rsp_i ( rd_rsp  ),
		.word_o    ( rd_word ),
		.idle_o    ( rd_idle )
	);

	write_dma u_write (
		.clk_i        ( clk_i    ),
		.rst_ni       ( rst_ni   ),
		.cmd_i        ( wr_cmd   ),
		.word_i       ( wr_word  ),
		.mgr_req_o    ( wr_req   ),
		.mgr_rsp_i    ( wr_rsp   ),
		.data_ready_o ( wr_ready ),
		.idle_o       ( wr_idle  )
	);

	mgr_arbiter u_arb (
		.clk_i     ( clk_i     ),
		.rst_ni    ( rst_ni    ),
		.wr_req_i  ( wr_req    ),
		.rd_req_i  ( rd_req    ),
		.wr_rsp_o  ( wr_rsp    ),
		.rd_rsp_o  ( rd_rsp    ),
		.mgr_req_o ( mgr_req_o ),
		.mgr_rsp_i ( mgr_rsp_i )
	);

endmodule

// File: tests/tb_checker.sv
module tb_checker import dma_pkg::*; #(
	parameter logic [7:0] MemOffset = 8'h30
) (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  obi_req_t sbr_req_i,
	input  obi_rsp_t sbr_rsp_i,
	input  obi_req_t mgr_req_i,
	input  obi_rsp_t mgr_rsp_i,
	output int       err_cnt_o,
	output int       chk_cnt_o
);
	timeunit 1ns;
	timeprecision 1ns;

	logic [7:0]  shadow [256]; // expected memory contents
	logic        written [256]; // bytes some write transfer covers
	logic        armed;
	logic [31:0] exp_val, exp_mask;
	logic        acc_q;     // any register access accepted
	logic        rd_pend_q;
	logic [2:0]  rd_off_q;

	initial begin
		for (int a = 0; a < 256; a++) begin
			shadow[a]  = 8'(a) + MemOffset; // same fill rule as the memory model
			written[a] = 1'b0;
		end
		armed     = 1'b0;
		err_cnt_o = 0;
		chk_cnt_o = 0;
	end

	// next register read is compared under a mask
	task automatic arm(input logic [31:0] val, input logic [31:0] mask);
		exp_val  = val;
		exp_mask = mask;
		armed    = 1'b1;
	endtask

	// capture word k holds stream word n-1-k
	task automatic arm_capture(input logic [7:0] addr, input int len, input int k);
		int          j;
		int          idx;
		logic [31:0] w;
		j = (len + 3) / 4 - 1 - k;
		w = '0;
		for (int b = 0; b < 4; b++) begin
			idx = 4 * j + b;
			if (idx < len) w[8*b +: 8] = shadow[8'(int'(addr) + idx)]; // zero past length
		end
		arm(w, '1);
	endtask

	task automatic model_write(input logic [7:0] addr, input int len,
			input logic [2:0][31:0] data);
		logic [7:0] a;
		for (int i = 0; i < len; i++) begin
			a          = 8'(int'(addr) + i);
			shadow[a]  = data[i / 4][8*(i % 4) +: 8];
			written[a] = 1'b1;
		end
	endtask

	//////////////////////////////////////
	// subordinate and manager monitors
	//////////////////////////////////////
	always @(posedge clk_i) begin
		if (!rst_ni) begin
			acc_q     <= 1'b0;
			rd_pend_q <= 1'b0;
		end else begin
			acc_q     <= sbr_req_i.req;
			rd_pend_q <= sbr_req_i.req && !sbr_req_i.we;
		end
		rd_off_q <= sbr_req_i.addr[4:2];
	end

	// register responses, mid cycle
	always @(negedge clk_i) begin
		if (rst_ni) begin
			if (sbr_req_i.req && !sbr_rsp_i.gnt) begin
				err_cnt_o = err_cnt_o + 1;
				$display("register request at %0t was not granted", $time);
			end
			if (acc_q && !sbr_rsp_i.rvalid) begin
				err_cnt_o = err_cnt_o + 1;
				$display("register access at %0t got no response", $time);
			end else if (!acc_q && sbr_rsp_i.rvalid) begin
				err_cnt_o = err_cnt_o + 1;
				$display("register response at %0t came without a request", $time);
			end else if (rd_pend_q && armed) begin
				chk_cnt_o = chk_cnt_o + 1;
				armed     = 1'b0;
				if ((sbr_rsp_i.rdata & exp_mask) != (exp_val & exp_mask)) begin
					err_cnt_o = err_cnt_o + 1;
					$display("FAIL %0t: offset %0d read %h, expected %h mask %h", $time,
						rd_off_q, sbr_rsp_i.rdata, exp_val, exp_mask);
				end
			end
		end
	end

	// every accepted memory write against the shadow
	always @(posedge clk_i) begin
		if (rst_ni && mgr_req_i.req && mgr_rsp_i.gnt && mgr_req_i.we) begin
			for (int b = 0; b < 4; b++) begin
				if (mgr_req_i.be[b]) begin
					if (!written[8'(mgr_req_i.addr[7:0] + b)]) begin
						err_cnt_o = err_cnt_o + 1;
						$display("memory write outside any transfer at byte %h, time %0t",
							8'(mgr_req_i.addr[7:0] + b), $time);
					end else if (mgr_req_i.wdata[8*b +: 8] !=
							shadow[8'(mgr_req_i.addr[7:0] + b)]) begin
						err_cnt_o = err_cnt_o + 1;
						$display("FAIL %0t: byte %h written %h, expected %h", $time,
							8'(mgr_req_i.addr[7:0] + b), mgr_req_i.wdata[8*b +: 8],
							shadow[8'(mgr_req_i.addr[7:0] + b)]);
					end
				end
			end
			chk_cnt_o = chk_cnt_o + 1;
		end
	end

endmodule

// File: tests/tb_top.sv
module tb_top import dma_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ns;

	localparam logic [7:0] MemOffset = 8'h30;
	localparam int         NumOps    = 17;
	localparam int         OpBudget  = 400; // cycles per table entry

	typedef enum logic [1:0] {OpRegRd, OpRegWr, OpRdXfer, OpWrXfer} op_kind_e;

	typedef struct packed {
		op_kind_e          kind;
		logic [7:0]        addr; // offset or start byte
		logic [3:0]        len;
		logic [2:0][31:0]  data; // expected value, written value or pushed words
	} op_t;

	logic        clk = 1'b0;
	logic        rst_n;
	obi_req_t    sbr_req, mgr_req;
	obi_rsp_t    sbr_rsp, mgr_rsp;
	logic [7:0]  mem [256];
	op_t         ops [NumOps];
	int          err_cnt, chk_cnt;
	logic [31:0] rd;

	always #50 clk = ~clk;

	dma_top u_dut (
		.clk_i     ( clk     ),
		.rst_ni    ( rst_n   ),
		.sbr_req_i ( sbr_req ),
		.sbr_rsp_o ( sbr_rsp ),
		.mgr_req_o ( mgr_req ),
		.mgr_rsp_i ( mgr_rsp )
	);

	tb_checker #(.MemOffset(MemOffset)) u_chk (
		.clk_i     ( clk     ),
		.rst_ni    ( rst_n   ),
		.sbr_req_i ( sbr_req ),
		.sbr_rsp_i ( sbr_rsp ),
		.mgr_req_i ( mgr_req ),
		.mgr_rsp_i ( mgr_rsp ),
		.err_cnt_o ( err_cnt ),
		.chk_cnt_o ( chk_cnt )
	);

	//////////////////////////////////////
	// memory model, random gnt
	//////////////////////////////////////
	initial begin
		void'($urandom(85)); // one seed for the whole run
		mgr_rsp = '0;
		for (int a = 0; a < 256; a++) mem[a] = 8'(a) + MemOffset;
		forever begin
			@(posedge clk);
			if (!rst_n) begin
				mgr_rsp <= '0;
			end else begin
				mgr_rsp.gnt    <= ($urandom % 4) != 0;
				mgr_rsp.rvalid <= mgr_req.req && mgr_rsp.gnt; // one cycle after grant
				if (mgr_req.req && mgr_rsp.gnt) begin
					for (int b = 0; b < 4; b++) begin
						mgr_rsp.rdata[8*b +: 8] <= mem[{mgr_req.addr[7:2], 2'(b)}];
						if (mgr_req.we && mgr_req.be[b])
							mem[{mgr_req.addr[7:2], 2'(b)}] <= mgr_req.wdata[8*b +: 8];
					end
				end
			end
		end
	end

	function automatic op_t make_op(input op_kind_e kind, input logic [7:0] addr,
			input int len, input logic [31:0] d0, input logic [31:0] d1,
			input logic [31:0] d2);
		op_t op;
		op.kind = kind;
		op.addr = addr;
		op.len  = 4'(len);
		op.data = {d2, d1, d0};
		return op;
	endfunction

	// one subordinate access, response sampled a cycle after acceptance
	task automatic reg_access(input logic we, input int off, input logic [31:0] wdata,
			output logic [31:0] rdata);
		@(posedge clk);
		sbr_req <= '{req: 1'b1, addr: 32'(off * 4), we: we, be: 4'hf, wdata: wdata};
		@(posedge clk);
		sbr_req.req <= 1'b0;
		@(posedge clk);
		rdata = sbr_rsp.rdata;
	endtask

	task automatic wait_status(input logic [31:0] mask);
		logic [31:0] st;
		st = '0;
		while ((st & mask) != mask) reg_access(1'b0, RegWrData, '0, st);
	endtask

	task automatic run_read(input logic [7:0] addr, input int len);
		logic [31:0] r;
		reg_access(1'b1, RegLen, 32'(len), r);
		wait_status(32'h4);
		reg_access(1'b1, RegRdCmd, 32'(addr), r);
		u_chk.arm(32'h0, 32'h4); // read engine busy
		reg_access(1'b0, RegWrData, '0, r);
		wait_status(32'h5);
		for (int k = 0; k < 3; k++) begin
			u_chk.arm_capture(addr, len, k);
			reg_access(1'b0, RegRdCmd + k, '0, r);
		end
		u_chk.arm(32'h5, 32'h5);
		reg_access(1'b0, RegWrData, '0, r);
	endtask

	task automatic run_write(input logic [7:0] addr, input int len,
			input logic [2:0][31:0] data);
		logic [31:0] r;
		reg_access(1'b1, RegLen, 32'(len), r);
		wait_status(32'h1);
		u_chk.model_write(addr, len, data);
		reg_access(1'b1, RegWrCmd, 32'(addr), r);
		u_chk.arm(32'h0, 32'h1); // write engine busy
		reg_access(1'b0, RegWrData, '0, r);
		for (int w = 0; w < (len + 3) / 4; w++) begin
			wait_status(32'h2); // data ready
			reg_access(1'b1, RegWrData, data[w], r);
		end
		wait_status(32'h1);
		u_chk.arm(32'h5, 32'h5);
		reg_access(1'b0, RegWrData, '0, r);
	endtask

	initial begin
		rst_n   = 1'b0;
		sbr_req = '0;
		ops[0]  = make_op(OpRegRd, 8'd4, 0, LenReset, 0, 0);
		ops[1]  = make_op(OpRegRd, 8'd0, 0, IdMagic, 0, 0);
		ops[2]  = make_op(OpRegRd, 8'd7, 0, FillWord, 0, 0);
		ops[3]  = make_op(OpRegWr, 8'd4, 0, 32'h1c, 0, 0);
		ops[4]  = make_op(OpRegRd, 8'd4, 0, 32'h1c, 0, 0);
		ops[5]  = make_op(OpRdXfer, 8'h10, 12, 0, 0, 0);
		ops[6]  = make_op(OpRdXfer, 8'h21, 11, 0, 0, 0); // second last word
		ops[7]  = make_op(OpRdXfer, 8'h32, 9, 0, 0, 0);
		ops[8]  = make_op(OpRdXfer, 8'h43, 10, 0, 0, 0);
		ops[9]  = make_op(OpWrXfer, 8'h80, 12, 32'h03020100, 32'h07060504, 32'h0b0a0908);
		ops[10] = make_op(OpWrXfer, 8'h91, 7, 32'ha1b2c3d4, 32'he5f60718, 0);
		ops[11] = make_op(OpWrXfer, 8'ha2, 10, 32'h11223344, 32'h55667788, 32'h99aabbcc);
		ops[12] = make_op(OpWrXfer, 8'hc3, 6, 32'hcafef00d, 32'h0badc0de, 0); // spills
		ops[13] = make_op(OpRdXfer, 8'h91, 11, 0, 0, 0);
		ops[14] = make_op(OpRdXfer, 8'ha2, 10, 0, 0, 0);
		ops[15] = make_op(OpRdXfer, 8'hc1, 12, 0, 0, 0);
		ops[16] = make_op(OpRdXfer, 8'h7f, 12, 0, 0, 0);
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < NumOps; i++) begin
			case (ops[i].kind)
				OpRegRd: begin
					u_chk.arm(ops[i].data[0], '1);
					reg_access(1'b0, int'(ops[i].addr), '0, rd);
				end
				OpRegWr:  reg_access(1'b1, int'(ops[i].addr), ops[i].data[0], rd);
				OpRdXfer: run_read(ops[i].addr, int'(ops[i].len));
				default:  run_write(ops[i].addr, int'(ops[i].len), ops[i].data);
			endcase
		end
		repeat (2) @(posedge clk);
		$display("checks %0d errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(NumOps * OpBudget * 100);
		$display("watchdog timeout, the table did not finish in time");
		$display("Something failed");
		$finish;
	end

endmodule

// File: build.f
verilog/dma_pkg.sv
verilog/dma_regs.sv
verilog/read_dma.sv
verilog/write_dma.sv
verilog/mgr_arbiter.sv
verilog/dma_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_top
FILELIST  = build.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
